/* hdl/regfile_geom_pkg.sv */
//======================================================================
// register file geometry
// widths, counts and address field helpers for the banked register
// file, an entry address is tile index, half select, row (low to high)
//======================================================================
package regfile_geom_pkg;

  localparam int DATA_WIDTH = 64;
  localparam int TILE_BITS = 2;
  localparam int TILE_COUNT = 1 << TILE_BITS;
  localparam int ROW_BITS = 4;
  localparam int ROW_COUNT = 1 << ROW_BITS;
  localparam int ADDR_WIDTH = TILE_BITS + 1 + ROW_BITS;
  localparam int ENTRY_COUNT = 1 << ADDR_WIDTH;
  localparam int READ_PORTS = 3;
  localparam int WRITE_PORTS = 2;

  typedef logic [DATA_WIDTH-1:0] reg_data_t;
  typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [ROW_BITS-1:0] row_addr_t;
  typedef logic [TILE_BITS-1:0] tile_idx_t;

  function automatic tile_idx_t addr_tile(reg_addr_t addr);
    return addr[TILE_BITS-1:0];
  endfunction

  function automatic logic addr_half(reg_addr_t addr);
    return addr[TILE_BITS];
  endfunction

  function automatic row_addr_t addr_row(reg_addr_t addr);
    return addr[ADDR_WIDTH-1 -: ROW_BITS];
  endfunction

endpackage

/* hdl/regfile_port_pkg.sv */
//======================================================================
// register file port types
// read and write requests as seen at the top level, plus the state
// encoding of the post-reset clearing sweep
//======================================================================
package regfile_port_pkg;

  // const_en returns const_val instead of the entry
  typedef struct packed {
    regfile_geom_pkg::reg_addr_t addr;
    logic const_en;
    regfile_geom_pkg::reg_data_t const_val;
  } read_req_t;

  typedef struct packed {
    regfile_geom_pkg::reg_addr_t addr;
    regfile_geom_pkg::reg_data_t data;
    logic wen;
  } write_req_t;

  typedef enum logic {
    SWEEP,
    IDLE
  } sweep_state_t;

endpackage

/* hdl/regfile_bank_ram.sv */
//======================================================================
// register file RAM half
// 16 rows with registered read and retire row addresses, combinational
// read from the held rows, so writes show up on the next cycle
//======================================================================
`timescale 1ns/100ps

module regfile_bank_ram #(
  parameter int READ_PORTS = regfile_geom_pkg::READ_PORTS,
  parameter int WRITE_PORTS = regfile_geom_pkg::WRITE_PORTS
) (
  input  logic clk,
  input  logic rst,
  input  logic read_clk_en,
  input  regfile_geom_pkg::row_addr_t read_row [READ_PORTS],
  input  logic retire_clk_en,
  input  regfile_geom_pkg::row_addr_t retire_row,
  input  regfile_geom_pkg::row_addr_t write_row [WRITE_PORTS],
  input  regfile_geom_pkg::reg_data_t write_data [WRITE_PORTS],
  input  logic write_en [WRITE_PORTS],
  output regfile_geom_pkg::reg_data_t read_data [READ_PORTS],
  output regfile_geom_pkg::reg_data_t retire_data
);

  regfile_geom_pkg::reg_data_t mem [regfile_geom_pkg::ROW_COUNT];
  regfile_geom_pkg::row_addr_t read_row_q [READ_PORTS];
  regfile_geom_pkg::row_addr_t retire_row_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < READ_PORTS; p++)
        read_row_q[p] <= '0;
      retire_row_q <= '0;
    end
    else
    begin
      // low enable is a stall, rows hold
      if (read_clk_en)
        read_row_q <= read_row;
      if (retire_clk_en)
        retire_row_q <= retire_row;
    end
  end

  // higher numbered port is applied last and wins a same-row collision
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < WRITE_PORTS; w++)
    begin
      if (write_en[w])
        mem[write_row[w]] <= write_data[w];
    end
  end

  always_comb
  begin
    for (int p = 0; p < READ_PORTS; p++)
      read_data[p] = mem[read_row_q[p]];
  end

  assign retire_data = mem[retire_row_q];

endmodule

/* hdl/regfile_tile.sv */
//======================================================================
// register file tile
// two RAM halves behind a tile index match; decodes writes to a half,
// registers per-port hit flags and drives zero on ports it does not own
//======================================================================
`timescale 1ns/100ps

module regfile_tile #(
  parameter regfile_geom_pkg::tile_idx_t TILE_INDEX = '0,
  parameter int READ_PORTS = regfile_geom_pkg::READ_PORTS,
  parameter int WRITE_PORTS = regfile_geom_pkg::WRITE_PORTS
) (
  input  logic clk,
  input  logic rst,
  input  logic read_clk_en,
  input  regfile_geom_pkg::reg_addr_t read_addr [READ_PORTS],
  input  logic retire_clk_en,
  input  regfile_geom_pkg::reg_addr_t retire_addr,
  input  regfile_port_pkg::write_req_t write_req [WRITE_PORTS],
  output regfile_geom_pkg::reg_data_t read_data [READ_PORTS],
  output regfile_geom_pkg::reg_data_t retire_data
);

  regfile_geom_pkg::row_addr_t read_row [READ_PORTS];
  regfile_geom_pkg::row_addr_t retire_row;
  regfile_geom_pkg::row_addr_t write_row [WRITE_PORTS];
  regfile_geom_pkg::reg_data_t write_data [WRITE_PORTS];
  logic write_en_a [WRITE_PORTS];
  logic write_en_b [WRITE_PORTS];
  logic [READ_PORTS-1:0] read_hit_a;
  logic [READ_PORTS-1:0] read_hit_b;
  logic retire_hit_a;
  logic retire_hit_b;
  regfile_geom_pkg::reg_data_t read_data_a [READ_PORTS];
  regfile_geom_pkg::reg_data_t read_data_b [READ_PORTS];
  regfile_geom_pkg::reg_data_t retire_data_a;
  regfile_geom_pkg::reg_data_t retire_data_b;

  function automatic logic tile_match(regfile_geom_pkg::reg_addr_t addr);
    return (regfile_geom_pkg::addr_tile(addr) == TILE_INDEX);
  endfunction

  // write decode, half select picks A (0) or B (1)
  always_comb
  begin
    for (int w = 0; w < WRITE_PORTS; w++)
    begin
      write_row[w] = regfile_geom_pkg::addr_row(write_req[w].addr);
      write_data[w] = write_req[w].data;
      write_en_a[w] = write_req[w].wen && tile_match(write_req[w].addr) &&
                      !regfile_geom_pkg::addr_half(write_req[w].addr);
      write_en_b[w] = write_req[w].wen && tile_match(write_req[w].addr) &&
                      regfile_geom_pkg::addr_half(write_req[w].addr);
    end
    for (int p = 0; p < READ_PORTS; p++)
      read_row[p] = regfile_geom_pkg::addr_row(read_addr[p]);
  end

  assign retire_row = regfile_geom_pkg::addr_row(retire_addr);

  // hit flags use the same enables as the row registers in the halves
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_hit_a <= '0;
      read_hit_b <= '0;
      retire_hit_a <= 1'b0;
      retire_hit_b <= 1'b0;
    end
    else
    begin
      if (read_clk_en)
      begin
        for (int p = 0; p < READ_PORTS; p++)
        begin
          read_hit_a[p] <= tile_match(read_addr[p]) &&
                           !regfile_geom_pkg::addr_half(read_addr[p]);
          read_hit_b[p] <= tile_match(read_addr[p]) &&
                           regfile_geom_pkg::addr_half(read_addr[p]);
        end
      end
      if (retire_clk_en)
      begin
        retire_hit_a <= tile_match(retire_addr) && !regfile_geom_pkg::addr_half(retire_addr);
        retire_hit_b <= tile_match(retire_addr) && regfile_geom_pkg::addr_half(retire_addr);
      end
    end
  end

  regfile_bank_ram #(
    .READ_PORTS(READ_PORTS),
    .WRITE_PORTS(WRITE_PORTS)
  ) half_a (
    .clk(clk),
    .rst(rst),
    .read_clk_en(read_clk_en),
    .read_row(read_row),
    .retire_clk_en(retire_clk_en),
    .retire_row(retire_row),
    .write_row(write_row),
    .write_data(write_data),
    .write_en(write_en_a),
    .read_data(read_data_a),
    .retire_data(retire_data_a)
  );

  regfile_bank_ram #(
    .READ_PORTS(READ_PORTS),
    .WRITE_PORTS(WRITE_PORTS)
  ) half_b (
    .clk(clk),
    .rst(rst),
    .read_clk_en(read_clk_en),
    .read_row(read_row),
    .retire_clk_en(retire_clk_en),
    .retire_row(retire_row),
    .write_row(write_row),
    .write_data(write_data),
    .write_en(write_en_b),
    .read_data(read_data_b),
    .retire_data(retire_data_b)
  );

  // zero when this tile was not addressed, so the top can OR tiles together
  always_comb
  begin
    for (int p = 0; p < READ_PORTS; p++)
      read_data[p] = read_hit_a[p] ? read_data_a[p] :
                     read_hit_b[p] ? read_data_b[p] : '0;
    retire_data = retire_hit_a ? retire_data_a :
                  retire_hit_b ? retire_data_b : '0;
  end

endmodule

/* hdl/regfile_clear_seq.sv */
//======================================================================
// register file clear sequencer
// after reset writes zero to every entry, one per cycle, on write
// port 0, then hands the port back to the external requester
//======================================================================
`timescale 1ns/100ps

module regfile_clear_seq #(
  parameter int ENTRY_COUNT = regfile_geom_pkg::ENTRY_COUNT
) (
  input  logic clk,
  input  logic rst,
  input  regfile_port_pkg::write_req_t ext_write,
  output regfile_port_pkg::write_req_t write_out,
  output logic init_busy
);

  regfile_port_pkg::sweep_state_t state;
  regfile_geom_pkg::reg_addr_t sweep_addr;
  logic last_entry;

  assign last_entry = (sweep_addr == regfile_geom_pkg::reg_addr_t'(ENTRY_COUNT - 1));
  assign init_busy = (state == regfile_port_pkg::SWEEP);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= regfile_port_pkg::SWEEP;
      sweep_addr <= '0;
    end
    else if (state == regfile_port_pkg::SWEEP)
    begin
      sweep_addr <= sweep_addr + 1'b1;
      if (last_entry)
        state <= regfile_port_pkg::IDLE;
    end
  end

  // external port 0 writes are dropped while sweeping
  always_comb
  begin
    if (state == regfile_port_pkg::SWEEP)
    begin
      write_out.addr = sweep_addr;
      write_out.data = '0;
      write_out.wen = 1'b1;
    end
    else
    begin
      write_out = ext_write;
    end
  end

endmodule

/* hdl/regfile_top.sv */
//======================================================================
// banked register file
// 128 entries in four tiles, three operand read ports with constant
// override, one retire read port, two write ports and a clear sweep
//======================================================================
`timescale 1ns/100ps

module regfile_top #(
  parameter int TILE_COUNT = regfile_geom_pkg::TILE_COUNT,
  parameter int READ_PORTS = regfile_geom_pkg::READ_PORTS,
  parameter int WRITE_PORTS = regfile_geom_pkg::WRITE_PORTS,
  parameter int ENTRY_COUNT = regfile_geom_pkg::ENTRY_COUNT
) (
  input  logic clk,
  input  logic rst,
  input  regfile_port_pkg::read_req_t read_req [READ_PORTS],
  input  logic read_clk_en,
  input  regfile_geom_pkg::reg_addr_t retire_addr,
  input  logic retire_clk_en,
  input  regfile_port_pkg::write_req_t write_req [WRITE_PORTS],
  output regfile_geom_pkg::reg_data_t read_data [READ_PORTS],
  output regfile_geom_pkg::reg_data_t retire_data,
  output logic init_busy
);

  regfile_port_pkg::write_req_t sweep_write;
  regfile_port_pkg::write_req_t tile_write [WRITE_PORTS];
  regfile_geom_pkg::reg_addr_t read_addr [READ_PORTS];
  regfile_geom_pkg::reg_data_t tile_read_data [TILE_COUNT][READ_PORTS];
  regfile_geom_pkg::reg_data_t tile_retire_data [TILE_COUNT];
  regfile_geom_pkg::reg_data_t merged_read [READ_PORTS];
  logic [READ_PORTS-1:0] const_en_q;
  regfile_geom_pkg::reg_data_t const_val_q [READ_PORTS];

  regfile_clear_seq #(
    .ENTRY_COUNT(ENTRY_COUNT)
  ) clear_seq_inst (
    .clk(clk),
    .rst(rst),
    .ext_write(write_req[0]),
    .write_out(sweep_write),
    .init_busy(init_busy)
  );

  // port 0 goes through the sequencer, the rest straight to the tiles
  always_comb
  begin
    tile_write[0] = sweep_write;
    for (int w = 1; w < WRITE_PORTS; w++)
      tile_write[w] = write_req[w];
    for (int p = 0; p < READ_PORTS; p++)
      read_addr[p] = read_req[p].addr;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      const_en_q <= '0;
      for (int p = 0; p < READ_PORTS; p++)
        const_val_q[p] <= '0;
    end
    else if (read_clk_en)
    begin
      for (int p = 0; p < READ_PORTS; p++)
      begin
        const_en_q[p] <= read_req[p].const_en;
        const_val_q[p] <= read_req[p].const_val;
      end
    end
  end

  for (genvar t = 0; t < TILE_COUNT; t++)
  begin : g_tile
    regfile_tile #(
      .TILE_INDEX(regfile_geom_pkg::tile_idx_t'(t)),
      .READ_PORTS(READ_PORTS),
      .WRITE_PORTS(WRITE_PORTS)
    ) tile_inst (
      .clk(clk),
      .rst(rst),
      .read_clk_en(read_clk_en),
      .read_addr(read_addr),
      .retire_clk_en(retire_clk_en),
      .retire_addr(retire_addr),
      .write_req(tile_write),
      .read_data(tile_read_data[t]),
      .retire_data(tile_retire_data[t])
    );
  end

  // only the addressed tile is nonzero, an OR is enough
  always_comb
  begin
    retire_data = '0;
    for (int p = 0; p < READ_PORTS; p++)
      merged_read[p] = '0;
    for (int t = 0; t < TILE_COUNT; t++)
    begin
      retire_data = retire_data | tile_retire_data[t];
      for (int p = 0; p < READ_PORTS; p++)
        merged_read[p] = merged_read[p] | tile_read_data[t][p];
    end
    for (int p = 0; p < READ_PORTS; p++)
      read_data[p] = const_en_q[p] ? const_val_q[p] : merged_read[p];
  end

endmodule

/* testbench/tb_regfile.sv */
//======================================================================
// banked register file testbench
// random traffic against a shadow model of the entries, covering the
// clear sweep, constant override, stall, write-first and retire port
//======================================================================
`timescale 1ns/100ps

module tb_regfile;

  localparam int TILE_COUNT = regfile_geom_pkg::TILE_COUNT;
  localparam int READ_PORTS = regfile_geom_pkg::READ_PORTS;
  localparam int WRITE_PORTS = regfile_geom_pkg::WRITE_PORTS;
  localparam int ENTRY_COUNT = regfile_geom_pkg::ENTRY_COUNT;
  localparam int INIT_TIMEOUT = 4 * ENTRY_COUNT;

  logic clk;
  logic rst;
  regfile_port_pkg::read_req_t read_req [READ_PORTS];
  logic read_clk_en;
  regfile_geom_pkg::reg_addr_t retire_addr;
  logic retire_clk_en;
  regfile_port_pkg::write_req_t write_req [WRITE_PORTS];
  regfile_geom_pkg::reg_data_t read_data [READ_PORTS];
  regfile_geom_pkg::reg_data_t retire_data;
  logic init_busy;

  integer seed = 32'h89d8_9219;
  int mismatch_count = 0;
  int timeout_count = 0;
  logic checking = 1'b0;

  // model of the entries and of what the read registers hold
  regfile_geom_pkg::reg_data_t shadow [regfile_geom_pkg::reg_addr_t];
  int sweep_next;
  regfile_geom_pkg::reg_addr_t held_addr [READ_PORTS];
  logic held_const_en [READ_PORTS];
  regfile_geom_pkg::reg_data_t held_const_val [READ_PORTS];
  regfile_geom_pkg::reg_addr_t held_retire;

  regfile_top #(
    .TILE_COUNT(TILE_COUNT),
    .READ_PORTS(READ_PORTS),
    .WRITE_PORTS(WRITE_PORTS),
    .ENTRY_COUNT(ENTRY_COUNT)
  ) regfile_top_inst (
    .clk(clk),
    .rst(rst),
    .read_req(read_req),
    .read_clk_en(read_clk_en),
    .retire_addr(retire_addr),
    .retire_clk_en(retire_clk_en),
    .write_req(write_req),
    .read_data(read_data),
    .retire_data(retire_data),
    .init_busy(init_busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic regfile_geom_pkg::reg_addr_t random_addr();
    return regfile_geom_pkg::reg_addr_t'($random(seed));
  endfunction

  function automatic regfile_geom_pkg::reg_data_t random_data();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [READ_PORTS-1:0] random_mask();
    int r;
    r = $random(seed);
    return r[READ_PORTS-1:0];
  endfunction

  function automatic logic random_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // the constant wins over the entry as the model last wrote it
  function automatic regfile_geom_pkg::reg_data_t expected_read(
    logic const_en,
    regfile_geom_pkg::reg_data_t const_val,
    regfile_geom_pkg::reg_addr_t addr
  );
    if (const_en)
      return const_val;
    if (!shadow.exists(addr))
      return 'x;
    return shadow[addr];
  endfunction

  // mirrors sweep, port order and the enable-gated read registers
  always @(posedge clk)
  begin
    if (rst)
    begin
      sweep_next = 0;
      for (int p = 0; p < READ_PORTS; p++)
      begin
        held_addr[p] = '0;
        held_const_en[p] = 1'b0;
        held_const_val[p] = '0;
      end
      held_retire = '0;
    end
    else
    begin
      if (sweep_next < ENTRY_COUNT)
      begin
        shadow[regfile_geom_pkg::reg_addr_t'(sweep_next)] = '0;
        sweep_next++;
      end
      else if (write_req[0].wen)
        shadow[write_req[0].addr] = write_req[0].data;
      if (write_req[1].wen)
        shadow[write_req[1].addr] = write_req[1].data;
      if (read_clk_en)
      begin
        for (int p = 0; p < READ_PORTS; p++)
        begin
          held_addr[p] = read_req[p].addr;
          held_const_en[p] = read_req[p].const_en;
          held_const_val[p] = read_req[p].const_val;
        end
      end
      if (retire_clk_en)
        held_retire = retire_addr;
    end
  end

  always @(negedge clk)
  begin : compare
    regfile_geom_pkg::reg_data_t expected;
    if (checking)
    begin
      for (int p = 0; p < READ_PORTS; p++)
      begin
        expected = expected_read(held_const_en[p], held_const_val[p], held_addr[p]);
        assert (read_data[p] === expected)
        else
        begin
          mismatch_count++;
          $display("Mismatch at %0t: read_data[%0d] expected %h actual %h",
                   $time, p, expected, read_data[p]);
        end
      end
      expected = expected_read(1'b0, '0, held_retire);
      assert (retire_data === expected)
      else
      begin
        mismatch_count++;
        $display("Mismatch at %0t: retire_data expected %h actual %h",
                 $time, expected, retire_data);
      end
    end
  end

  task automatic run_cycle(input logic do_write, input logic read_en,
                           input logic [READ_PORTS-1:0] const_mask, input logic retire_en);
    regfile_geom_pkg::reg_addr_t addr_0;
    regfile_geom_pkg::reg_addr_t addr_1;
    addr_0 = random_addr();
    addr_1 = random_addr();
    // both ports on one entry is kept out of the traffic
    if (addr_1 == addr_0)
      addr_1 = addr_0 ^ regfile_geom_pkg::reg_addr_t'(1);
    @(posedge clk);
    write_req[0] <= '{addr: addr_0, data: random_data(), wen: do_write};
    write_req[1] <= '{addr: addr_1, data: random_data(), wen: do_write};
    for (int p = 0; p < READ_PORTS; p++)
      read_req[p] <= '{addr: random_addr(), const_en: const_mask[p], const_val: random_data()};
    read_clk_en <= read_en;
    retire_addr <= random_addr();
    retire_clk_en <= retire_en;
  endtask

  // port 0 traffic during the sweep that the sequencer has to drop
  task automatic drive_sweep_writes();
    for (int i = 0; i < ENTRY_COUNT - 1; i++)
    begin
      @(posedge clk);
      write_req[0] <= '{addr: random_addr(), data: random_data(), wen: 1'b1};
    end
    @(posedge clk);
    write_req[0].wen <= 1'b0;
  endtask

  // write the entry that port 0 holds during a stall and expect it one cycle later
  task automatic write_held_entry();
    regfile_geom_pkg::reg_addr_t target;
    regfile_geom_pkg::reg_data_t value;
    @(negedge clk);
    target = held_addr[0];
    value = random_data();
    @(posedge clk);
    write_req[0].wen <= 1'b0;
    write_req[1] <= '{addr: target, data: value, wen: 1'b1};
    read_clk_en <= 1'b0;
    @(posedge clk);
    write_req[1].wen <= 1'b0;
    @(negedge clk);
    assert (read_data[0] === value)
    else
    begin
      mismatch_count++;
      $display("Mismatch at %0t: read_data[0] expected %h actual %h",
               $time, value, read_data[0]);
    end
  endtask

  task automatic wait_init_done();
    int busy_cycles;
    busy_cycles = 0;
    @(negedge clk);
    while (init_busy !== 1'b0 && busy_cycles < INIT_TIMEOUT)
    begin
      busy_cycles++;
      @(negedge clk);
    end
    assert (init_busy === 1'b0)
    else
    begin
      timeout_count++;
      $display("error: init_busy still high after %0d cycles, clear sweep never ended",
               busy_cycles);
    end
    assert (busy_cycles == ENTRY_COUNT)
    else
    begin
      mismatch_count++;
      $display("Mismatch at %0t: init_busy cycles expected %0d actual %0d",
               $time, ENTRY_COUNT, busy_cycles);
    end
  endtask

  initial
  begin
    rst = 1'b1;
    read_clk_en = 1'b0;
    retire_clk_en = 1'b0;
    retire_addr = '0;
    for (int p = 0; p < READ_PORTS; p++)
      read_req[p] = '0;
    for (int w = 0; w < WRITE_PORTS; w++)
      write_req[w] = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    fork
      wait_init_done();
      drive_sweep_writes();
    join
    @(posedge clk);
    checking = 1'b1;

    // every entry reads zero after the sweep
    repeat (20) run_cycle(1'b0, 1'b1, '0, 1'b1);
    repeat (60) run_cycle(1'b1, 1'b0, '0, 1'b0);
    repeat (60) run_cycle(1'b0, 1'b1, '0, 1'b0);
    repeat (30) run_cycle(1'b1, 1'b1, random_mask(), 1'b0);
    repeat (5)
    begin
      run_cycle(1'b0, 1'b1, '0, 1'b0);
      repeat (4) run_cycle(1'b0, 1'b0, '0, 1'b0);
      write_held_entry();
    end
    // retire enable toggles apart from the read enable
    repeat (60) run_cycle(random_bit(), random_bit(), '0, random_bit());
    run_cycle(1'b0, 1'b0, '0, 1'b0);
    @(negedge clk);
    @(posedge clk);

    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* regfile.f */
hdl/regfile_geom_pkg.sv
hdl/regfile_port_pkg.sv
hdl/regfile_bank_ram.sv
hdl/regfile_tile.sv
hdl/regfile_clear_seq.sv
hdl/regfile_top.sv
testbench/tb_regfile.sv

/* run_sim.sh */
#!/bin/sh
# build the register file testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f regfile.f --top-module tb_regfile -o tb_regfile

out=$(./obj_dir/tb_regfile)
echo "$out"

# exit status comes from the search for the pass line
echo "$out" | grep -q "^SIMULATION PASSED$"
